/* design/mips_exec_params.svh */
// Widths and field positions assume the standard 32-bit MIPS instruction layout and are fixed
`ifndef MIPS_EXEC_PARAMS_SVH
`define MIPS_EXEC_PARAMS_SVH

// Data path and HI/LO register width
`define DATA_W 32

// ALU operation code width
`define OP_W 6

// Shift amount field, read by the ALU from input_1 for immediate shifts
`define SHAMT_LSB 6
`define SHAMT_MSB 10

`endif

/* design/mips_exec_pkg.sv */
// R-type fields are only meaningful when the opcode is zero; OP_NONE always yields a zero result
`default_nettype none

`include "mips_exec_params.svh"

package mips_exec_pkg;

	typedef struct packed {
		logic [5:0]                       opcode;  // Zero for R-type
		logic [4:0]                       rs;
		logic [4:0]                       rt;
		logic [4:0]                       rd;
		logic [`SHAMT_MSB-`SHAMT_LSB:0]   shamt;
		logic [5:0]                       funct;
	} r_fields_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;  // Extended by the decoder
	} i_fields_t;

	// One instruction word seen two ways, picked by the opcode
	typedef union packed {
		r_fields_t r;
		i_fields_t i;
	} instr_word_t;

	typedef enum logic [`OP_W-1:0] {
		OP_SLL   = 6'b000000,
		OP_SRL   = 6'b000001,  // Not the MIPS funct value
		OP_SRA   = 6'b000011,
		OP_SLLV  = 6'b000100,
		OP_SRLV  = 6'b000110,
		OP_SRAV  = 6'b000111,
		OP_MFHI  = 6'b010000,
		OP_MTHI  = 6'b010001,
		OP_MFLO  = 6'b010010,
		OP_MTLO  = 6'b010011,
		OP_MULT  = 6'b011000,
		OP_MULTU = 6'b011001,
		OP_DIV   = 6'b011010,
		OP_DIVU  = 6'b011011,
		OP_ADD   = 6'b100000,
		OP_ADDU  = 6'b100001,
		OP_SUB   = 6'b100010,
		OP_SUBU  = 6'b100011,
		OP_AND   = 6'b100100,
		OP_OR    = 6'b100101,
		OP_XOR   = 6'b100110,
		OP_NOR   = 6'b100111,
		OP_SLT   = 6'b101010,
		OP_SLTU  = 6'b101011,
		OP_LUI   = 6'b101100,
		OP_NONE  = 6'b111111   // Unrecognised instruction
	} alu_op_t;

endpackage

`default_nettype wire

/* design/instr_decoder.sv */
// Unknown opcodes and functs decode to OP_NONE; immediate shifts pass the whole word as operand_1
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_params.svh"

module instr_decoder import mips_exec_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               instr_valid,
	input  instr_word_t        instr,
	input  logic [`DATA_W-1:0] rs_value,
	input  logic [`DATA_W-1:0] rt_value,
	output logic               op_valid,
	output alu_op_t            op,
	output logic [`DATA_W-1:0] operand_1,
	output logic [`DATA_W-1:0] operand_2
);

	localparam int W = `DATA_W;

	alu_op_t      dec_op;
	logic [W-1:0] dec_operand_1;
	logic [W-1:0] dec_operand_2;
	logic [W-1:0] imm_sext;
	logic [W-1:0] imm_zext;

	assign imm_sext = W'($signed(instr.i.imm));
	assign imm_zext = W'(instr.i.imm);

	always_comb begin
		dec_op        = OP_NONE;
		dec_operand_1 = rs_value;
		dec_operand_2 = rt_value;
		if (instr.r.opcode == 6'b000000) begin  // R-type
			case (instr.r.funct)
				6'b000000: dec_op = OP_SLL;
				6'b000010: dec_op = OP_SRL;
				6'b000011: dec_op = OP_SRA;
				6'b000100: dec_op = OP_SLLV;
				6'b000110: dec_op = OP_SRLV;
				6'b000111: dec_op = OP_SRAV;
				6'b010000: dec_op = OP_MFHI;
				6'b010001: dec_op = OP_MTHI;
				6'b010010: dec_op = OP_MFLO;
				6'b010011: dec_op = OP_MTLO;
				6'b011000: dec_op = OP_MULT;
				6'b011001: dec_op = OP_MULTU;
				6'b011010: dec_op = OP_DIV;
				6'b011011: dec_op = OP_DIVU;
				6'b100000: dec_op = OP_ADD;
				6'b100001: dec_op = OP_ADDU;
				6'b100010: dec_op = OP_SUB;
				6'b100011: dec_op = OP_SUBU;
				6'b100100: dec_op = OP_AND;
				6'b100101: dec_op = OP_OR;
				6'b100110: dec_op = OP_XOR;
				6'b100111: dec_op = OP_NOR;
				6'b101010: dec_op = OP_SLT;
				6'b101011: dec_op = OP_SLTU;
				default:   dec_op = OP_NONE;
			endcase
			// ALU takes shamt from bits 10:6 of operand_1
			if (dec_op == OP_SLL || dec_op == OP_SRL || dec_op == OP_SRA) begin
				dec_operand_1 = instr;
			end
		end else begin
			dec_operand_2 = imm_sext;  // ADDI, ADDIU, SLTI, SLTIU
			case (instr.i.opcode)
				6'b001000: dec_op = OP_ADD;   // ADDI wraps
				6'b001001: dec_op = OP_ADDU;
				6'b001010: dec_op = OP_SLT;
				6'b001011: dec_op = OP_SLTU;
				6'b001100: dec_op = OP_AND;
				6'b001101: dec_op = OP_OR;
				6'b001110: dec_op = OP_XOR;
				6'b001111: dec_op = OP_LUI;
				default:   dec_op = OP_NONE;
			endcase
			if (instr.i.opcode[2]) begin  // ANDI, ORI, XORI, LUI
				dec_operand_2 = imm_zext;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			op_valid  <= 1'b0;
			op        <= OP_NONE;
			operand_1 <= '0;
			operand_2 <= '0;
		end else begin
			op_valid <= instr_valid;
			if (instr_valid) begin  // Hold last operation otherwise
				op        <= dec_op;
				operand_1 <= dec_operand_1;
				operand_2 <= dec_operand_2;
			end
		end
	end

endmodule

`default_nettype wire

/* design/alu.sv */
// Divide puts the quotient in HI and the remainder in LO; overflow never traps and no X is produced
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_params.svh"

module alu import mips_exec_pkg::*; (
	input  alu_op_t              op,
	input  logic [`DATA_W-1:0]   input_1,
	input  logic [`DATA_W-1:0]   input_2,
	output logic [`DATA_W-1:0]   alu_output,
	output logic [2*`DATA_W-1:0] hi_lo_output,
	output logic                 hi_write,
	output logic                 lo_write
);

	localparam int W = `DATA_W;

	logic [`SHAMT_MSB-`SHAMT_LSB:0] shift_amount;
	logic [4:0]                     var_amount;
	logic [2*W-1:0]                 product_s;
	logic [2*W-1:0]                 product_u;
	logic [W-1:0]                   quot_s;
	logic [W-1:0]                   rem_s;
	logic [W-1:0]                   quot_u;
	logic [W-1:0]                   rem_u;
	logic                           div_zero;
	logic                           div_ovf;

	assign shift_amount = input_1[`SHAMT_MSB:`SHAMT_LSB];
	assign var_amount   = input_1[4:0];
	assign product_s    = $signed({{W{input_1[W-1]}}, input_1}) * $signed({{W{input_2[W-1]}}, input_2});
	assign product_u    = {{W{1'b0}}, input_1} * {{W{1'b0}}, input_2};
	assign div_zero     = (input_2 == '0);
	assign div_ovf      = (input_1 == {1'b1, {(W-1){1'b0}}}) && (input_2 == '1);

	always_comb begin
		quot_u = '1;  // Divide by zero
		rem_u  = input_1;
		quot_s = '1;
		rem_s  = input_1;
		if (!div_zero) begin
			quot_u = input_1 / input_2;
			rem_u  = input_1 % input_2;
			if (div_ovf) begin  // Most negative over -1 wraps
				quot_s = input_1;
				rem_s  = '0;
			end else begin
				quot_s = $signed(input_1) / $signed(input_2);
				rem_s  = $signed(input_1) % $signed(input_2);
			end
		end
	end

	always_comb begin
		alu_output   = '0;  // Also the result for unknown codes
		hi_lo_output = '0;
		hi_write     = 1'b0;
		lo_write     = 1'b0;
		case (op)
			OP_SLL:  alu_output = input_2 << shift_amount;
			OP_SRL:  alu_output = input_2 >> shift_amount;
			OP_SRA:  alu_output = $signed(input_2) >>> shift_amount;
			OP_SLLV: alu_output = input_2 << var_amount;
			OP_SRLV: alu_output = input_2 >> var_amount;
			OP_SRAV: alu_output = $signed(input_2) >>> var_amount;
			OP_MFHI, OP_MFLO: alu_output = input_2;  // Swapped in by the execute stage
			OP_MTHI: begin
				alu_output   = input_2;
				hi_lo_output = {input_1, {W{1'b0}}};
				hi_write     = 1'b1;
			end
			OP_MTLO: begin
				alu_output   = input_2;
				hi_lo_output = {{W{1'b0}}, input_1};
				lo_write     = 1'b1;
			end
			OP_MULT, OP_MULTU, OP_DIV, OP_DIVU: begin
				hi_write = 1'b1;
				lo_write = 1'b1;
				case (op)
					OP_MULT:  hi_lo_output = product_s;
					OP_MULTU: hi_lo_output = product_u;
					OP_DIV:   hi_lo_output = {quot_s, rem_s};
					default:  hi_lo_output = {quot_u, rem_u};
				endcase
			end
			OP_ADD, OP_ADDU: alu_output = input_1 + input_2;  // No overflow trap
			OP_SUB, OP_SUBU: alu_output = input_1 - input_2;
			OP_AND:  alu_output = input_1 & input_2;
			OP_OR:   alu_output = input_1 | input_2;
			OP_XOR:  alu_output = input_1 ^ input_2;
			OP_NOR:  alu_output = ~(input_1 | input_2);
			OP_SLT:  alu_output = {{(W-1){1'b0}}, $signed(input_1) < $signed(input_2)};
			OP_SLTU: alu_output = {{(W-1){1'b0}}, input_1 < input_2};
			OP_LUI:  alu_output = input_2 << (W / 2);
			default: alu_output = '0;  // Includes OP_NONE
		endcase
	end

endmodule

`default_nettype wire

/* design/exec_stage.sv */
// HI/LO are read straight from the registers, so MFHI right after MULT sees the new value
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_params.svh"

module exec_stage import mips_exec_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               op_valid,
	input  alu_op_t            op,
	input  logic [`DATA_W-1:0] operand_1,
	input  logic [`DATA_W-1:0] operand_2,
	input  logic [`DATA_W-1:0] hi,
	input  logic [`DATA_W-1:0] lo,
	output logic               hi_write,
	output logic               lo_write,
	output logic [`DATA_W-1:0] hi_next,
	output logic [`DATA_W-1:0] lo_next,
	output logic               result_valid,
	output logic [`DATA_W-1:0] result
);

	localparam int W = `DATA_W;

	logic [W-1:0]   alu_in_2;
	logic [W-1:0]   alu_result;
	logic [2*W-1:0] alu_hi_lo;
	logic           alu_hi_write;
	logic           alu_lo_write;

	always_comb begin
		case (op)
			OP_MFHI: alu_in_2 = hi;
			OP_MFLO: alu_in_2 = lo;
			default: alu_in_2 = operand_2;
		endcase
	end

	alu u_alu (
		.op           (op),
		.input_1      (operand_1),
		.input_2      (alu_in_2),
		.alu_output   (alu_result),
		.hi_lo_output (alu_hi_lo),
		.hi_write     (alu_hi_write),
		.lo_write     (alu_lo_write)
	);

	assign hi_write = op_valid & alu_hi_write;  // Same edge as the result
	assign lo_write = op_valid & alu_lo_write;
	assign hi_next  = alu_hi_lo[2*W-1:W];
	assign lo_next  = alu_hi_lo[W-1:0];

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
			result       <= '0;
		end else begin
			result_valid <= op_valid;
			if (op_valid) begin
				result <= alu_result;
			end
		end
	end

endmodule

`default_nettype wire

/* design/hilo_regs.sv */
// Both registers clear on reset; each loads only on its own write enable
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_params.svh"

module hilo_regs (
	input  logic               clk,
	input  logic               reset,
	input  logic               hi_write,
	input  logic               lo_write,
	input  logic [`DATA_W-1:0] hi_next,
	input  logic [`DATA_W-1:0] lo_next,
	output logic [`DATA_W-1:0] hi,
	output logic [`DATA_W-1:0] lo
);

	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
		end else begin
			if (hi_write) begin
				hi <= hi_next;  // MTHI, multiply or divide
			end
			if (lo_write) begin
				lo <= lo_next;  // MTLO, multiply or divide
			end
		end
	end

endmodule

`default_nettype wire

/* design/mips_exec.sv */
// One instruction per cycle, no back-pressure; result_valid trails instr_valid by two cycles
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_params.svh"

module mips_exec import mips_exec_pkg::*; (
	input  logic               clk,
	input  logic               reset,
	input  logic               instr_valid,
	input  instr_word_t        instr,
	input  logic [`DATA_W-1:0] rs_value,
	input  logic [`DATA_W-1:0] rt_value,
	output logic               result_valid,
	output logic [`DATA_W-1:0] result,
	output logic [`DATA_W-1:0] hi,
	output logic [`DATA_W-1:0] lo
);

	logic               op_valid;
	alu_op_t            op;
	logic [`DATA_W-1:0] operand_1;
	logic [`DATA_W-1:0] operand_2;
	logic               hi_write;
	logic               lo_write;
	logic [`DATA_W-1:0] hi_next;
	logic [`DATA_W-1:0] lo_next;

	instr_decoder u_decoder (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs_value    (rs_value),
		.rt_value    (rt_value),
		.op_valid    (op_valid),
		.op          (op),
		.operand_1   (operand_1),
		.operand_2   (operand_2)
	);

	exec_stage u_exec (
		.clk          (clk),
		.reset        (reset),
		.op_valid     (op_valid),
		.op           (op),
		.operand_1    (operand_1),
		.operand_2    (operand_2),
		.hi           (hi),
		.lo           (lo),
		.hi_write     (hi_write),
		.lo_write     (lo_write),
		.hi_next      (hi_next),
		.lo_next      (lo_next),
		.result_valid (result_valid),
		.result       (result)
	);

	hilo_regs u_hilo (
		.clk      (clk),
		.reset    (reset),
		.hi_write (hi_write),
		.lo_write (lo_write),
		.hi_next  (hi_next),
		.lo_next  (lo_next),
		.hi       (hi),
		.lo       (lo)
	);

endmodule

`default_nettype wire

/* dv/mips_exec_props.sv */
// Sees only the top-level ports; the latency check is skipped for two cycles after reset
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_params.svh"

module mips_exec_props (
	input logic               clk,
	input logic               reset,
	input logic               instr_valid,
	input logic               result_valid,
	input logic [`DATA_W-1:0] result,
	input logic [`DATA_W-1:0] hi,
	input logic [`DATA_W-1:0] lo
);

	int fail_count = 0;  // Read by the testbench summary

	reset_clears_outputs: assert property (@(posedge clk)
		reset |=> !result_valid && hi == '0 && lo == '0)
	else begin
		fail_count++;
		$error("result_valid, hi or lo not cleared by reset");
	end

	// Two register stages between instr_valid and result_valid
	valid_latency: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) && !$past(reset, 2) |-> result_valid == $past(instr_valid, 2))
	else begin
		fail_count++;
		$error("result_valid does not follow instr_valid by two cycles");
	end

	result_known: assert property (@(posedge clk) result_valid |-> !$isunknown(result))
	else begin
		fail_count++;
		$error("result unknown while result_valid is high");
	end

endmodule

bind mips_exec mips_exec_props u_props (
	.clk          (clk),
	.reset        (reset),
	.instr_valid  (instr_valid),
	.result_valid (result_valid),
	.result       (result),
	.hi           (hi),
	.lo           (lo)
);

`default_nettype wire

/* dv/mips_exec_tb.sv */
// Stimulus comes from a fixed xorshift seed and outputs are compared on the falling edge two cycles after each issue
`timescale 1ns/1ps
`default_nettype none

`include "mips_exec_params.svh"

module mips_exec_tb import mips_exec_pkg::*; ();

	localparam int          CLK_PERIOD  = 100;
	localparam logic [31:0] SEED        = 32'd89738;
	localparam int          N_ALU       = 400;
	localparam int          N_SHIFT     = 300;
	localparam int          N_IMM       = 300;
	localparam int          N_HILO      = 400;
	localparam int          N_UNK       = 100;
	localparam int          N_MIX       = 500;
	localparam int          TOTAL       = N_ALU + N_SHIFT + N_IMM + N_HILO + N_UNK + N_MIX;
	localparam int          WATCHDOG_NS = (TOTAL + TOTAL / 4 + 100) * CLK_PERIOD;  // Room for bubbles and drains

	// Funct codes and the ALU operation each must decode to
	localparam logic [5:0] R_FUNCT [24] = '{
		6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,                // Shifts
		6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b,  // HI/LO
		6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
	};
	localparam alu_op_t R_OP [24] = '{
		OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
		OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO, OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SLT, OP_SLTU
	};
	// Opcodes 0x08 to 0x0f where the first four sign-extend
	localparam alu_op_t I_OP [8] = '{
		OP_ADD, OP_ADDU, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR, OP_LUI
	};

	logic               clk = 1'b0;
	logic               reset;
	logic               instr_valid;
	instr_word_t        instr;
	logic [`DATA_W-1:0] rs_value;
	logic [`DATA_W-1:0] rt_value;
	logic               result_valid;
	logic [`DATA_W-1:0] result;
	logic [`DATA_W-1:0] hi;
	logic [`DATA_W-1:0] lo;

	logic               q_valid[$];  // One entry per issued cycle
	logic [`DATA_W-1:0] q_result[$];
	logic [`DATA_W-1:0] q_hi[$];
	logic [`DATA_W-1:0] q_lo[$];
	alu_op_t            q_op[$];

	logic [31:0] rng;
	logic [31:0] model_hi;
	logic [31:0] model_lo;
	string       test_name;
	int          errors       = 0;
	int          checks       = 0;
	int          test_errors  = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;

	mips_exec uut (
		.clk          (clk),
		.reset        (reset),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.rs_value     (rs_value),
		.rt_value     (rt_value),
		.result_valid (result_valid),
		.result       (result),
		.hi           (hi),
		.lo           (lo)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw(output logic [31:0] r);
		rng = xorshift32(rng);
		r   = rng;
	endtask

	// Corner values for wraparound and signed compares
	task automatic draw_operand(output logic [31:0] v);
		logic [31:0] r;
		draw(r);
		case (r[2:0])
			3'd0:    v = 32'h0000_0000;
			3'd1:    v = 32'hffff_ffff;
			3'd2:    v = 32'h8000_0000;
			3'd3:    v = 32'h7fff_ffff;
			default: draw(v);
		endcase
	endtask

	task automatic check_word(input string name, input logic [`DATA_W-1:0] expected,
			input logic [`DATA_W-1:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			test_errors++;
			$display("FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			test_errors++;
			$display("FAILED %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic check_op(input string name, input alu_op_t expected, input alu_op_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			test_errors++;
			$display("FAILED %s: expected %s, actual %s (%h)", name, expected.name(),
				actual.name(), actual);
		end
	endtask

	// Reference model updating model_hi and model_lo in program order
	task automatic model_exec(input alu_op_t op, input logic [31:0] a, input logic [31:0] b,
			input logic [4:0] amount, output logic [31:0] res);
		longint      prod_s;
		logic [63:0] prod_u;
		longint      quot;
		longint      remd;
		res = 32'h0;
		case (op)
			OP_SLL, OP_SLLV: res = b << amount;
			OP_SRL, OP_SRLV: res = b >> amount;
			OP_SRA, OP_SRAV: res = $signed(b) >>> amount;
			OP_ADD, OP_ADDU: res = a + b;  // Wraps without a trap
			OP_SUB, OP_SUBU: res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_NOR:  res = ~(a | b);
			OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			OP_SLTU: res = (a < b) ? 32'd1 : 32'd0;
			OP_LUI:  res = {b[15:0], 16'h0000};
			OP_MFHI: res = model_hi;
			OP_MFLO: res = model_lo;
			OP_MTHI: begin
				model_hi = a;
				res      = b;  // Passes rt through
			end
			OP_MTLO: begin
				model_lo = a;
				res      = b;
			end
			OP_MULT: begin
				prod_s               = longint'($signed(a)) * longint'($signed(b));
				{model_hi, model_lo} = prod_s;
			end
			OP_MULTU: begin
				prod_u               = {32'h0, a} * {32'h0, b};
				{model_hi, model_lo} = prod_u;
			end
			OP_DIV: begin
				if (b == 32'h0) begin
					model_hi = 32'hffff_ffff;
					model_lo = a;
				end else begin
					quot     = longint'($signed(a)) / longint'($signed(b));
					remd     = longint'($signed(a)) % longint'($signed(b));
					model_hi = quot[31:0];  // Quotient in HI
					model_lo = remd[31:0];
				end
			end
			OP_DIVU: begin
				if (b == 32'h0) begin
					model_hi = 32'hffff_ffff;
					model_lo = a;
				end else begin
					model_hi = a / b;
					model_lo = a % b;
				end
			end
			default: res = 32'h0;
		endcase
	endtask

	// Kind 0 is ALU, 1 shifts, 2 immediates, 3 HI/LO, 4 unknown and 5 any of these
	task automatic make_instr(input int kind, output instr_word_t w, output alu_op_t op,
			output logic [31:0] rs, output logic [31:0] rt, output logic [31:0] b,
			output logic [4:0] amount);
		logic [31:0] fields;
		logic [31:0] sel;
		int          idx;
		int          group;
		draw(fields);
		draw(sel);
		draw_operand(rs);
		draw_operand(rt);
		w     = fields;
		op    = OP_NONE;
		b     = rt;
		group = (kind == 5) ? int'(sel[31:8] % 5) : kind;
		case (group)
			0:       idx = 14 + int'(sel[7:0] % 10);
			1:       idx = int'(sel[7:0] % 6);
			3:       idx = 6 + int'(sel[7:0] % 8);
			default: idx = int'(sel[2:0]);
		endcase
		if (group == 2) begin
			w.i.opcode = 6'(8 + idx);
			op         = I_OP[idx];
			b          = (idx < 4) ? {{16{w.i.imm[15]}}, w.i.imm} : {16'h0000, w.i.imm};
		end else if (group == 4) begin
			if (sel[3]) begin
				w.r.opcode = 6'h00;
				w.r.funct  = {3'b001, sel[2:0]};  // JR, SYSCALL and the like
			end else begin
				w.i.opcode = {1'b1, sel[8:4]};  // Loads and stores
			end
		end else begin
			w.r.opcode = 6'h00;
			w.r.funct  = R_FUNCT[idx];
			op         = R_OP[idx];
		end
		amount = (op == OP_SLLV || op == OP_SRLV || op == OP_SRAV) ? rs[4:0] : w.r.shamt;
	endtask

	task automatic issue(input logic valid, input instr_word_t w, input logic [31:0] rs,
			input logic [31:0] rt, input alu_op_t op, input logic [31:0] exp_result);
		@(negedge clk);
		if (q_valid.size() == 2) begin  // Issued two cycles ago
			check_bit({test_name, " result_valid"}, q_valid[0], result_valid);
			if (q_valid[0]) begin
				check_word({test_name, " result"}, q_result[0], result);
			end
			check_word({test_name, " hi"}, q_hi[0], hi);
			check_word({test_name, " lo"}, q_lo[0], lo);
			void'(q_valid.pop_front());
			void'(q_result.pop_front());
			void'(q_hi.pop_front());
			void'(q_lo.pop_front());
			void'(q_op.pop_front());
		end
		if (q_valid.size() == 1 && q_valid[0]) begin  // Decoded at the last rising edge
			check_op({test_name, " decode"}, q_op[0], uut.u_decoder.op);
		end
		instr_valid = valid;
		instr       = w;
		rs_value    = rs;
		rt_value    = rt;
		q_valid.push_back(valid);
		q_result.push_back(exp_result);
		q_hi.push_back(model_hi);
		q_lo.push_back(model_lo);
		q_op.push_back(op);
	endtask

	task automatic run_test(input string name, input int kind, input int count);
		instr_word_t w;
		alu_op_t     op;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] b;
		logic [4:0]  amount;
		logic [31:0] res;
		logic [31:0] gap;
		test_name   = name;
		test_errors = 0;
		for (int n = 0; n < count; n++) begin
			draw(gap);
			if (gap[3:0] == 4'd0) begin
				issue(1'b0, '0, '0, '0, OP_NONE, '0);  // Bubble
			end
			make_instr(kind, w, op, rs, rt, b, amount);
			model_exec(op, rs, b, amount, res);
			issue(1'b1, w, rs, rt, op, res);
		end
		repeat (2) issue(1'b0, '0, '0, '0, OP_NONE, '0);  // Drain
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("test %s: %0d instructions, %0d errors", name, count, test_errors);
	endtask

	initial begin
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		rs_value    = '0;
		rt_value    = '0;
		rng         = SEED;
		model_hi    = '0;
		model_lo    = '0;
		repeat (2) @(negedge clk);  // Two rising edges in reset
		reset       = 1'b0;
		test_name   = "reset";
		check_bit({test_name, " result_valid"}, 1'b0, result_valid);
		check_word({test_name, " result"}, '0, result);
		check_word({test_name, " hi"}, '0, hi);
		check_word({test_name, " lo"}, '0, lo);
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		$display("test %s: %0d errors", test_name, test_errors);
		run_test("alu_rtype", 0, N_ALU);
		run_test("shifts", 1, N_SHIFT);
		run_test("immediates", 2, N_IMM);
		run_test("hilo", 3, N_HILO);
		run_test("unknown", 4, N_UNK);
		run_test("mixed", 5, N_MIX);
		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, uut.u_props.fail_count);
		if (errors == 0 && uut.u_props.fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/mips_exec_pkg.sv
design/instr_decoder.sv
design/alu.sv
design/exec_stage.sv
design/hilo_regs.sv
design/mips_exec.sv
dv/mips_exec_props.sv
dv/mips_exec_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= mips_exec_tb
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
		echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
